// ==== common/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ****************************************
// core dimensions
// ****************************************

// hardware threads sharing the execute datapath
`define CPU_N_THREADS 4

// general purpose registers in each thread bank
`define CPU_N_REGS 4

// register and memory data word
`define CPU_DATA_W 16

// instruction store address, 64 words
`define CPU_IADDR_W 6

// one instruction word
`define CPU_INSTR_W 16

// per-thread offset into memory,
// the thread number is prepended on the bus
`define CPU_MADDR_W 8

`endif

// ==== common/isa_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package isa_pkg;

	// field widths, opcode sits in the top bits
	localparam int OPCODE_W = 4;
	localparam int REG_W = $clog2(`CPU_N_REGS);
	localparam int COND_W = 2;
	localparam int IMM_W = 8;

	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP,
		OP_MV_R_C,
		OP_ADD_R_C,
		OP_SUB_R_C,
		OP_AND_R_C,
		OP_SHR1,
		OP_MV_R_MEM,
		OP_MV_OUT_R,
		OP_JMP,
		OP_HALT
	} opcode_e;

	// condition checked against flags as they were before the instruction
	typedef enum logic [COND_W-1:0] {
		COND_ALWAYS,
		COND_ZERO,
		COND_NZERO,
		COND_CARRY
	} cond_e;

	// opcode | reg | cond | imm
	typedef struct packed {
		opcode_e op;
		logic [REG_W-1:0] rd;
		cond_e cond;
		logic [IMM_W-1:0] imm;
	} instr_t;

endpackage

`default_nettype wire

// ==== common/thread_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package thread_pkg;

	localparam int THREAD_W = $clog2(`CPU_N_THREADS);

	// index of a hardware thread
	typedef logic [THREAD_W-1:0] thread_num_t;

	// a thread either waits for a start or competes for the datapath
	typedef enum logic {
		TS_IDLE,
		TS_RUN
	} thread_state_e;

endpackage

`default_nettype wire

// ==== hdl/int_alu.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module int_alu (
	input wire isa_pkg::opcode_e op,
	input wire [`CPU_DATA_W-1:0] a,
	input wire [isa_pkg::IMM_W-1:0] imm,
	output logic [`CPU_DATA_W-1:0] result,
	output logic zf,
	output logic cf
);
	import isa_pkg::*;

	logic [`CPU_DATA_W-1:0] imm_ext;

	// immediate is zero extended
	assign imm_ext = {{(`CPU_DATA_W-IMM_W){1'b0}}, imm};

	always_comb begin
		result = a;
		cf = 1'b0;
		case (op)
			OP_MV_R_C: result = imm_ext;
			// carry out of the top bit
			OP_ADD_R_C: {cf, result} = {1'b0, a} + {1'b0, imm_ext};
			// top bit set here is a borrow
			OP_SUB_R_C: {cf, result} = {1'b0, a} - {1'b0, imm_ext};
			OP_AND_R_C: result = a & imm_ext;
			OP_SHR1: begin
				result = {1'b0, a[`CPU_DATA_W-1:1]};
				cf = a[0];
			end
			default: begin
			end
		endcase
		zf = (result == '0);
	end

endmodule

`default_nettype wire

// ==== cpu/thread_sched.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module thread_sched (
	input wire CLK,
	input wire rst,
	input wire prog_we,
	input wire [`CPU_IADDR_W-1:0] prog_addr,
	input wire [`CPU_INSTR_W-1:0] prog_data,
	input wire cfg_start,
	input wire thread_pkg::thread_num_t cfg_thread,
	input wire [`CPU_IADDR_W-1:0] cfg_entry,
	input wire pc_step,
	input wire pc_load,
	input wire [`CPU_IADDR_W-1:0] jump_addr,
	input wire halt,
	input wire switch,
	output thread_pkg::thread_num_t cur_thread,
	output logic cur_valid,
	output logic [`CPU_INSTR_W-1:0] instr,
	output logic busy
);
	import thread_pkg::*;

	localparam int N = `CPU_N_THREADS;

	logic [`CPU_INSTR_W-1:0] imem [2**`CPU_IADDR_W];
	logic [`CPU_IADDR_W-1:0] pc [N];
	thread_state_e ts [N];
	thread_num_t nxt_thread;
	logic do_switch;

	// ****************************************
	// instruction store
	// ****************************************
	// registered read at the current thread's pc,
	// the word is valid one cycle after a thread or pc change
	always_ff @(posedge CLK) begin
		if (prog_we) begin
			imem[prog_addr] <= prog_data;
		end
		instr <= imem[pc[cur_thread]];
	end

	// ****************************************
	// round-robin choice
	// ****************************************
	// nearest running thread after the current one wins,
	// loop runs far to near so the nearest overwrites
	always_comb begin
		thread_num_t cand;
		nxt_thread = cur_thread;
		for (int i = N - 1; i >= 1; i--) begin
			cand = thread_num_t'((int'(cur_thread) + i) % N);
			if (ts[cand] == TS_RUN) begin
				nxt_thread = cand;
			end
		end
	end

	always_comb begin
		busy = 1'b0;
		for (int i = 0; i < N; i++) begin
			busy = busy | (ts[i] == TS_RUN);
		end
	end

	assign cur_valid = (ts[cur_thread] == TS_RUN);

	// an idle current thread also moves on, that way a freshly
	// started thread is picked up while the core waits in fetch
	assign do_switch = switch | pc_load | halt | ~cur_valid;

	always_ff @(posedge CLK) begin
		if (rst) begin
			cur_thread <= '0;
			for (int i = 0; i < N; i++) begin
				ts[i] <= TS_IDLE;
				pc[i] <= '0;
			end
		end else begin
			// start of a running thread is dropped
			if (cfg_start && ts[cfg_thread] == TS_IDLE) begin
				pc[cfg_thread] <= cfg_entry;
				ts[cfg_thread] <= TS_RUN;
			end
			if (pc_load) begin
				pc[cur_thread] <= jump_addr;
			end else if (pc_step) begin
				pc[cur_thread] <= pc[cur_thread] + 1'b1;
			end
			if (halt) begin
				ts[cur_thread] <= TS_IDLE;
			end
			if (do_switch) begin
				cur_thread <= nxt_thread;
			end
		end
	end

endmodule

`default_nettype wire

// ==== cpu/thread_regs.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module thread_regs (
	input wire CLK,
	input wire rst,
	input wire thread_pkg::thread_num_t rd_thread,
	input wire [$clog2(`CPU_N_REGS)-1:0] rd_addr,
	input wire wr_en,
	input wire thread_pkg::thread_num_t wr_thread,
	input wire [$clog2(`CPU_N_REGS)-1:0] wr_addr,
	input wire [`CPU_DATA_W-1:0] wr_data,
	input wire flag_en,
	input wire zf_in,
	input wire cf_in,
	output logic [`CPU_DATA_W-1:0] rd_data,
	output logic zf,
	output logic cf
);
	localparam int N = `CPU_N_THREADS;
	localparam int R = `CPU_N_REGS;

	logic [`CPU_DATA_W-1:0] regs [N][R];
	logic zf_q [N];
	logic cf_q [N];

	// ****************************************
	// register banks
	// ****************************************
	// one bank per thread, all cleared on reset
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int t = 0; t < N; t++) begin
				for (int r = 0; r < R; r++) begin
					regs[t][r] <= '0;
				end
				zf_q[t] <= 1'b0;
				cf_q[t] <= 1'b0;
			end
		end else begin
			if (wr_en) begin
				regs[wr_thread][wr_addr] <= wr_data;
			end
			// zf and cf always move together
			if (flag_en) begin
				zf_q[wr_thread] <= zf_in;
				cf_q[wr_thread] <= cf_in;
			end
		end
	end

	// synchronous read, data is there the cycle after the address
	always_ff @(posedge CLK) begin
		rd_data <= regs[rd_thread][rd_addr];
	end

	// flags of the selected thread go straight to the condition check
	assign zf = zf_q[rd_thread];
	assign cf = cf_q[rd_thread];

endmodule

`default_nettype wire

// ==== cpu/cpu_core.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module cpu_core (
	input wire CLK,
	input wire rst,
	input wire thread_pkg::thread_num_t cur_thread,
	input wire cur_valid,
	input wire [`CPU_INSTR_W-1:0] instr,
	input wire [`CPU_DATA_W-1:0] rd_data,
	input wire zf,
	input wire cf,
	input wire [`CPU_DATA_W-1:0] alu_result,
	input wire alu_zf,
	input wire alu_cf,
	input wire mem_ack,
	input wire [`CPU_DATA_W-1:0] mem_data,
	input wire out_ack,
	output logic pc_step,
	output logic pc_load,
	output logic [`CPU_IADDR_W-1:0] jump_addr,
	output logic halt,
	output logic switch,
	output logic [isa_pkg::REG_W-1:0] rd_addr,
	output logic wr_en,
	output logic [isa_pkg::REG_W-1:0] wr_addr,
	output logic [`CPU_DATA_W-1:0] wr_data,
	output logic flag_en,
	output logic zf_wr,
	output logic cf_wr,
	output isa_pkg::opcode_e alu_op,
	output logic [isa_pkg::IMM_W-1:0] alu_imm,
	output logic mem_req,
	output logic [thread_pkg::THREAD_W+`CPU_MADDR_W-1:0] mem_addr,
	output logic out_req,
	output thread_pkg::thread_num_t out_thread,
	output logic [`CPU_DATA_W-1:0] out_data
);
	import isa_pkg::*;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_DECODE,
		ST_EXEC,
		ST_MEM,
		ST_OUT
	} state_e;

	state_e st;
	instr_t ir;
	instr_t dec;
	logic cond_true;
	logic exec_go;
	logic sets_flags;

	// ****************************************
	// decode
	// ****************************************
	// word from the store is valid in ST_DECODE,
	// register read is issued from it in the same cycle
	assign dec = instr_t'(instr);
	assign rd_addr = dec.rd;

	// execute stage works from the latched word
	assign alu_op = ir.op;
	assign alu_imm = ir.imm;
	assign jump_addr = ir.imm[`CPU_IADDR_W-1:0];
	assign zf_wr = alu_zf;
	assign cf_wr = alu_cf;

	always_comb begin
		case (ir.cond)
			COND_ZERO: cond_true = zf;
			COND_NZERO: cond_true = ~zf;
			COND_CARRY: cond_true = cf;
			default: cond_true = 1'b1;
		endcase
	end

	assign exec_go = (st == ST_EXEC) && cond_true;

	// MV_R_C writes the register but leaves the flags alone
	assign sets_flags = (ir.op == OP_ADD_R_C) || (ir.op == OP_SUB_R_C)
		|| (ir.op == OP_AND_R_C) || (ir.op == OP_SHR1);

	// ****************************************
	// write back and scheduler controls
	// ****************************************
	always_comb begin
		pc_step = 1'b0;
		pc_load = 1'b0;
		halt = 1'b0;
		switch = 1'b0;
		wr_en = 1'b0;
		flag_en = 1'b0;
		wr_addr = ir.rd;
		wr_data = alu_result;
		case (st)
			ST_EXEC: begin
				if (!cond_true) begin
					// skipped instruction still steps the pc
					pc_step = 1'b1;
				end else begin
					case (ir.op)
						OP_MV_R_C, OP_ADD_R_C, OP_SUB_R_C, OP_AND_R_C, OP_SHR1: begin
							wr_en = 1'b1;
							flag_en = sets_flags;
							pc_step = 1'b1;
						end
						// both finish after their handshake
						OP_MV_R_MEM, OP_MV_OUT_R: begin
						end
						// scheduler switches thread on these two
						OP_JMP: pc_load = 1'b1;
						OP_HALT: halt = 1'b1;
						default: pc_step = 1'b1;
					endcase
				end
			end
			ST_MEM: begin
				wr_data = mem_data;
				// data is written on the ack, once
				wr_en = mem_req & mem_ack;
				// falling ack ends the load, datapath goes to the next thread
				if (!mem_req && !mem_ack) begin
					pc_step = 1'b1;
					switch = 1'b1;
				end
			end
			ST_OUT: begin
				// output does not give up the datapath
				pc_step = ~out_req & ~out_ack;
			end
			default: begin
			end
		endcase
	end

	// ****************************************
	// state machine and handshakes
	// ****************************************
	always_ff @(posedge CLK) begin
		if (rst) begin
			st <= ST_FETCH;
			mem_req <= 1'b0;
			out_req <= 1'b0;
		end else begin
			case (st)
				// hold here while no thread runs
				ST_FETCH: begin
					if (cur_valid) begin
						st <= ST_DECODE;
					end
				end
				ST_DECODE: st <= ST_EXEC;
				ST_EXEC: begin
					if (exec_go && ir.op == OP_MV_R_MEM) begin
						st <= ST_MEM;
						mem_req <= 1'b1;
					end else if (exec_go && ir.op == OP_MV_OUT_R) begin
						st <= ST_OUT;
						out_req <= 1'b1;
					end else begin
						st <= ST_FETCH;
					end
				end
				ST_MEM: begin
					if (mem_req && mem_ack) begin
						mem_req <= 1'b0;
					end else if (!mem_req && !mem_ack) begin
						st <= ST_FETCH;
					end
				end
				ST_OUT: begin
					if (out_req && out_ack) begin
						out_req <= 1'b0;
					end else if (!out_req && !out_ack) begin
						st <= ST_FETCH;
					end
				end
				default: st <= ST_FETCH;
			endcase
		end
	end

	// payload, stable for the whole handshake
	always_ff @(posedge CLK) begin
		if (st == ST_DECODE) begin
			ir <= dec;
		end
		if (st == ST_EXEC) begin
			mem_addr <= {cur_thread, ir.imm[`CPU_MADDR_W-1:0]};
			out_thread <= cur_thread;
			out_data <= rd_data;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cpu_top.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module cpu_top (
	input wire CLK,
	input wire rst,
	input wire prog_we,
	input wire [`CPU_IADDR_W-1:0] prog_addr,
	input wire [`CPU_INSTR_W-1:0] prog_data,
	input wire cfg_start,
	input wire thread_pkg::thread_num_t cfg_thread,
	input wire [`CPU_IADDR_W-1:0] cfg_entry,
	output logic busy,
	output logic mem_req,
	output logic [thread_pkg::THREAD_W+`CPU_MADDR_W-1:0] mem_addr,
	input wire mem_ack,
	input wire [`CPU_DATA_W-1:0] mem_data,
	output logic out_req,
	output thread_pkg::thread_num_t out_thread,
	output logic [`CPU_DATA_W-1:0] out_data,
	input wire out_ack
);
	import isa_pkg::*;
	import thread_pkg::*;

	thread_num_t cur_thread;
	logic cur_valid;
	logic [`CPU_INSTR_W-1:0] instr;
	logic pc_step;
	logic pc_load;
	logic halt;
	logic switch;
	logic [`CPU_IADDR_W-1:0] jump_addr;
	logic [REG_W-1:0] rd_addr;
	logic [REG_W-1:0] wr_addr;
	logic [`CPU_DATA_W-1:0] rd_data;
	logic [`CPU_DATA_W-1:0] wr_data;
	logic [`CPU_DATA_W-1:0] alu_result;
	logic wr_en;
	logic flag_en;
	logic zf_wr;
	logic cf_wr;
	logic zf;
	logic cf;
	logic alu_zf;
	logic alu_cf;
	opcode_e alu_op;
	logic [IMM_W-1:0] alu_imm;

	// ****************************************
	// thread choice and instruction supply
	// ****************************************
	thread_sched u_sched (
		.CLK(CLK), .rst(rst),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.cfg_start(cfg_start), .cfg_thread(cfg_thread), .cfg_entry(cfg_entry),
		.pc_step(pc_step), .pc_load(pc_load), .jump_addr(jump_addr),
		.halt(halt), .switch(switch),
		.cur_thread(cur_thread), .cur_valid(cur_valid), .instr(instr), .busy(busy)
	);

	// one instruction in flight at a time
	cpu_core u_core (
		.CLK(CLK), .rst(rst),
		.cur_thread(cur_thread), .cur_valid(cur_valid), .instr(instr),
		.rd_data(rd_data), .zf(zf), .cf(cf),
		.alu_result(alu_result), .alu_zf(alu_zf), .alu_cf(alu_cf),
		.mem_ack(mem_ack), .mem_data(mem_data), .out_ack(out_ack),
		.pc_step(pc_step), .pc_load(pc_load), .jump_addr(jump_addr),
		.halt(halt), .switch(switch),
		.rd_addr(rd_addr), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.flag_en(flag_en), .zf_wr(zf_wr), .cf_wr(cf_wr),
		.alu_op(alu_op), .alu_imm(alu_imm),
		.mem_req(mem_req), .mem_addr(mem_addr),
		.out_req(out_req), .out_thread(out_thread), .out_data(out_data)
	);

	// read and write both go to the current thread's bank
	thread_regs u_regs (
		.CLK(CLK), .rst(rst),
		.rd_thread(cur_thread), .rd_addr(rd_addr),
		.wr_en(wr_en), .wr_thread(cur_thread), .wr_addr(wr_addr), .wr_data(wr_data),
		.flag_en(flag_en), .zf_in(zf_wr), .cf_in(cf_wr),
		.rd_data(rd_data), .zf(zf), .cf(cf)
	);

	int_alu u_alu (
		.op(alu_op), .a(rd_data), .imm(alu_imm),
		.result(alu_result), .zf(alu_zf), .cf(alu_cf)
	);

endmodule

`default_nettype wire

// ==== verif/tb_cpu.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu;
	import isa_pkg::*;
	import thread_pkg::*;

	localparam int N = `CPU_N_THREADS;
	localparam int R = `CPU_N_REGS;
	localparam int DW = `CPU_DATA_W;
	localparam int IAW = `CPU_IADDR_W;
	localparam int AW = THREAD_W + `CPU_MADDR_W;
	localparam int IMEM_WORDS = 2 ** IAW;
	// each thread owns one slice of the instruction store
	localparam int REGION = IMEM_WORDS / N;
	localparam int ROUNDS = 12;
	localparam int BODY_MAX = 12;
	localparam int DELAY_MAX = 12;
	// worst case per instruction is 3 cycles, a switch and two slow ack phases
	localparam int WATCHDOG_CYCLES =
		ROUNDS * (IMEM_WORDS + 2 * N + N * BODY_MAX * (10 + 2 * DELAY_MAX)) + 20;

	logic CLK;
	logic rst;
	logic prog_we;
	logic [IAW-1:0] prog_addr;
	logic [`CPU_INSTR_W-1:0] prog_data;
	logic cfg_start;
	thread_num_t cfg_thread;
	logic [IAW-1:0] cfg_entry;
	logic busy;
	logic mem_req;
	logic [AW-1:0] mem_addr;
	logic mem_ack;
	logic [DW-1:0] mem_data;
	logic out_req;
	thread_num_t out_thread;
	logic [DW-1:0] out_data;
	logic out_ack;

	int seed = 32'h47d7_513c;
	int max_delay = 2;
	logic [`CPU_INSTR_W-1:0] prog [IMEM_WORDS];
	logic [IAW-1:0] entry [N];
	// registers of the reference model survive from one round to the next
	logic [DW-1:0] m_regs [N][R];
	logic m_zf [N];
	logic m_cf [N];
	thread_num_t exp_out_t [$];
	logic [DW-1:0] exp_out_d [$];
	logic [AW-1:0] exp_addr [$];

	cpu_top dut (
		.CLK(CLK), .rst(rst),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.cfg_start(cfg_start), .cfg_thread(cfg_thread), .cfg_entry(cfg_entry),
		.busy(busy),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_data(mem_data),
		.out_req(out_req), .out_thread(out_thread), .out_data(out_data), .out_ack(out_ack)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// ****************************************
	// helpers and compare tasks
	// ****************************************
	function automatic int rand_below(input int k);
		rand_below = int'($unsigned($random(seed)) % k);
	endfunction

	// memory contents where every address bit reaches the data
	function automatic logic [DW-1:0] mix_addr(input logic [AW-1:0] addr);
		logic [DW-1:0] x;
		x = {{(DW-AW){1'b0}}, addr} * 16'h9e37;
		mix_addr = x ^ {addr[DW-AW-1:0], addr} ^ 16'h3c5a;
	endfunction

	function automatic logic [`CPU_INSTR_W-1:0] enc(input opcode_e op, input int rd,
			input cond_e c, input int imm);
		instr_t w;
		w.op = op;
		w.rd = rd[REG_W-1:0];
		w.cond = c;
		w.imm = imm[IMM_W-1:0];
		enc = w;
	endfunction

	task automatic fail_with(input string line);
		$display("%s", line);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_out(input thread_num_t exp_t, input thread_num_t got_t,
			input logic [DW-1:0] exp_d, input logic [DW-1:0] got_d);
		if (got_t !== exp_t) begin
			fail_with($sformatf("error at %0t: out_thread expected %0d got %0d",
				$time, exp_t, got_t));
		end else if (got_d !== exp_d) begin
			fail_with($sformatf("error at %0t: out_data expected %h got %h",
				$time, exp_d, got_d));
		end
	endtask

	task automatic check_addr(input logic [AW-1:0] exp_a, input logic [AW-1:0] got_a);
		if (got_a !== exp_a) begin
			fail_with($sformatf("error at %0t: mem_addr expected %h got %h",
				$time, exp_a, got_a));
		end
	endtask

	task automatic check_busy(input logic exp_b);
		if (busy !== exp_b) begin
			fail_with($sformatf("error at %0t: busy expected %b got %b", $time, exp_b, busy));
		end
	endtask

	// ****************************************
	// handshake responders
	// ****************************************
	// both sample on the falling edge where the core outputs are settled
	initial begin
		mem_ack = 1'b0;
		mem_data = '0;
		forever begin
			@(negedge CLK);
			if (mem_req && !mem_ack) begin
				if (exp_addr.size() == 0) begin
					fail_with("memory read issued that the reference model did not predict");
				end else begin
					check_addr(exp_addr.pop_front(), mem_addr);
					repeat (rand_below(max_delay + 1)) @(negedge CLK);
					mem_data = mix_addr(mem_addr);
					mem_ack = 1'b1;
				end
			end else if (!mem_req && mem_ack) begin
				repeat (rand_below(max_delay + 1)) @(negedge CLK);
				mem_ack = 1'b0;
			end
		end
	end

	// a late ack here stalls every thread
	initial begin
		out_ack = 1'b0;
		forever begin
			@(negedge CLK);
			if (out_req && !out_ack) begin
				if (exp_out_d.size() == 0) begin
					fail_with("output word sent that the reference model did not predict");
				end else begin
					check_out(exp_out_t.pop_front(), out_thread,
						exp_out_d.pop_front(), out_data);
					repeat (rand_below(max_delay + 1)) @(negedge CLK);
					out_ack = 1'b1;
				end
			end else if (!out_req && out_ack) begin
				repeat (rand_below(max_delay + 1)) @(negedge CLK);
				out_ack = 1'b0;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		fail_with("watchdog expired, the threads did not finish in time");
	end

	// ****************************************
	// program builder and reference model
	// ****************************************
	// two leading nops keep the first thread from switching
	// before all started threads are running
	task automatic build_programs();
		int base;
		int n;
		int p;
		int last;
		int r;
		int imm;
		cond_e c;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			prog[i] = enc(OP_HALT, 0, COND_ALWAYS, i);
		end
		for (int t = 0; t < N; t++) begin
			base = t * REGION + rand_below(4);
			entry[t] = base[IAW-1:0];
			n = 4 + rand_below(5);
			last = base + 2 + n;
			prog[base] = enc(OP_NOP, 0, COND_ALWAYS, 0);
			prog[base + 1] = enc(OP_NOP, 0, COND_ALWAYS, 0);
			for (int i = 0; i < n; i++) begin
				p = base + 2 + i;
				r = rand_below(R);
				c = cond_e'(rand_below(4));
				imm = rand_below(256);
				case (rand_below(8))
					0: prog[p] = enc(OP_MV_R_C, r, c, imm);
					1: prog[p] = enc(OP_ADD_R_C, r, c, imm);
					2: prog[p] = enc(OP_SUB_R_C, r, c, imm);
					3: prog[p] = enc(OP_AND_R_C, r, c, imm);
					4: prog[p] = enc(OP_SHR1, r, c, 0);
					5: prog[p] = enc(OP_MV_R_MEM, r, c, imm);
					6: prog[p] = enc(OP_MV_OUT_R, r, c, 0);
					// forward only and at most up to the closing output
					default: prog[p] = enc(OP_JMP, 0, c, p + 1 + rand_below(last - p));
				endcase
			end
			prog[last] = enc(OP_MV_OUT_R, rand_below(R), COND_ALWAYS, 0);
			prog[last + 1] = enc(OP_HALT, 0, COND_ALWAYS, 0);
		end
	endtask

	// first running thread found after cur with wrap-around
	function automatic thread_num_t next_running(input thread_num_t cur,
			input logic [N-1:0] run);
		thread_num_t cand;
		logic found;
		next_running = cur;
		found = 1'b0;
		for (int i = 1; i < N; i++) begin
			cand = thread_num_t'((int'(cur) + i) % N);
			if (!found && run[cand]) begin
				next_running = cand;
				found = 1'b1;
			end
		end
	endfunction

	task automatic write_alu(input thread_num_t t, input logic [REG_W-1:0] rd,
			input logic [DW-1:0] value, input logic carry);
		m_regs[t][rd] = value;
		m_zf[t] = (value == '0);
		m_cf[t] = carry;
	endtask

	task automatic run_model(input thread_num_t first, input logic [N-1:0] mask);
		logic [IAW-1:0] mpc [N];
		logic [N-1:0] run;
		thread_num_t cur;
		instr_t w;
		logic taken;
		logic sw;
		logic [DW-1:0] a;
		logic [DW-1:0] k;
		logic [DW:0] wide;
		for (int t = 0; t < N; t++) begin
			mpc[t] = entry[t];
		end
		run = mask;
		cur = first;
		while (run != '0) begin
			w = instr_t'(prog[mpc[cur]]);
			a = m_regs[cur][w.rd];
			k = {{(DW-IMM_W){1'b0}}, w.imm};
			// flags as left by the previous instruction of this thread
			case (w.cond)
				COND_ZERO: taken = m_zf[cur];
				COND_NZERO: taken = !m_zf[cur];
				COND_CARRY: taken = m_cf[cur];
				default: taken = 1'b1;
			endcase
			sw = 1'b0;
			mpc[cur] = mpc[cur] + 1'b1;
			if (taken) begin
				case (w.op)
					OP_MV_R_C: m_regs[cur][w.rd] = k;
					OP_ADD_R_C: begin
						wide = {1'b0, a} + {1'b0, k};
						write_alu(cur, w.rd, wide[DW-1:0], wide[DW]);
					end
					// carry reads as borrow
					OP_SUB_R_C: write_alu(cur, w.rd, a - k, a < k);
					OP_AND_R_C: write_alu(cur, w.rd, a & k, 1'b0);
					OP_SHR1: write_alu(cur, w.rd, a >> 1, a[0]);
					OP_MV_R_MEM: begin
						m_regs[cur][w.rd] = mix_addr({cur, w.imm});
						exp_addr.push_back({cur, w.imm});
						sw = 1'b1;
					end
					OP_MV_OUT_R: begin
						exp_out_t.push_back(cur);
						exp_out_d.push_back(a);
					end
					OP_JMP: begin
						mpc[cur] = w.imm[IAW-1:0];
						sw = 1'b1;
					end
					OP_HALT: begin
						run[cur] = 1'b0;
						sw = 1'b1;
					end
					default: begin
					end
				endcase
			end
			if (sw) begin
				cur = next_running(cur, run);
			end
		end
	endtask

	// ****************************************
	// stimulus
	// ****************************************
	task automatic start_thread(input thread_num_t t, input logic [IAW-1:0] addr);
		cfg_start = 1'b1;
		cfg_thread = t;
		cfg_entry = addr;
		@(negedge CLK);
		cfg_start = 1'b0;
	endtask

	task automatic run_round(input int idx);
		logic [N-1:0] mask;
		int rot;
		thread_num_t t;
		thread_num_t order [$];
		// second half of the rounds holds the acks back for long
		max_delay = (idx < ROUNDS / 2) ? 2 : DELAY_MAX;
		build_programs();
		mask = N'(rand_below(2 ** N));
		if (mask == '0) begin
			mask = '1;
		end
		rot = rand_below(N);
		for (int i = 0; i < N; i++) begin
			t = thread_num_t'((rot + i) % N);
			if (mask[t]) begin
				order.push_back(t);
			end
		end
		run_model(order[0], mask);
		// store is written only while no thread runs
		for (int i = 0; i < IMEM_WORDS; i++) begin
			prog_we = 1'b1;
			prog_addr = i[IAW-1:0];
			prog_data = prog[i];
			@(negedge CLK);
		end
		prog_we = 1'b0;
		foreach (order[i]) begin
			start_thread(order[i], entry[order[i]]);
		end
		// a start aimed at a running thread must be dropped
		// or the thread would land on the halt fill at the end of its region
		start_thread(order[0], IAW'(int'(order[0]) * REGION + REGION - 1));
		check_busy(1'b1);
		while (busy) begin
			@(negedge CLK);
		end
		if (exp_out_d.size() != 0 || exp_addr.size() != 0) begin
			fail_with("all threads halted before every expected output and load was seen");
		end
		repeat (2) @(negedge CLK);
		check_busy(1'b0);
	endtask

	initial begin
		rst = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		cfg_start = 1'b0;
		cfg_thread = '0;
		cfg_entry = '0;
		for (int t = 0; t < N; t++) begin
			for (int r = 0; r < R; r++) begin
				m_regs[t][r] = '0;
			end
			m_zf[t] = 1'b0;
			m_cf[t] = 1'b0;
		end
		repeat (5) @(negedge CLK);
		rst = 1'b0;
		check_busy(1'b0);
		for (int i = 0; i < ROUNDS; i++) begin
			run_round(i);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/isa_pkg.sv
common/thread_pkg.sv
hdl/int_alu.sv
cpu/thread_sched.sv
cpu/thread_regs.sv
cpu/cpu_core.sv
hdl/cpu_top.sv
verif/tb_cpu.sv

// ==== Makefile ====
# Verilator flow for the barrel-threaded core

VERILATOR ?= verilator
TOP ?= tb_cpu
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LINT_FLAGS ?= -Wall
BUILD_FLAGS ?= -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary --timing $(BUILD_FLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf $(OBJ_DIR)
